// ==== verilog/vdp_pkg.sv ====
// NTSC timing only; the register numbers cover the subset of V9958 registers this core keeps
`default_nettype none

package vdp_pkg;

  // ----------------------------------------
  // Raster timing
  // ----------------------------------------
  localparam int CLOCKS_PER_LINE = 1368;
  localparam int LINES_PER_FRAME = 262;
  localparam int ACTIVE_LINES    = 192;
  localparam int H_CNT_W         = $clog2(CLOCKS_PER_LINE);
  localparam int LINE_W          = 9;

  // ----------------------------------------
  // VRAM and register file
  // ----------------------------------------
  localparam int VRAM_ADDR_W = 17;
  localparam int REG_NUM_W   = 6;

  localparam logic [REG_NUM_W-1:0] R_MODE0      = 6'd0;
  localparam logic [REG_NUM_W-1:0] R_MODE1      = 6'd1;
  localparam logic [REG_NUM_W-1:0] R_VRAM_HI    = 6'd14;
  localparam logic [REG_NUM_W-1:0] R_STATUS_PTR = 6'd15;
  localparam logic [REG_NUM_W-1:0] R_INT_LINE   = 6'd19;

  // Interrupt enable bits in R0 and R1
  localparam int IE1_BIT = 4;
  localparam int IE0_BIT = 5;

  // Four clocks per dot, CPU owns the PH_1 slot
  typedef enum logic [1:0] {
    PH_0 = 2'd0,
    PH_1 = 2'd1,
    PH_2 = 2'd2,
    PH_3 = 2'd3
  } dot_phase_t;

  typedef enum logic [1:0] {
    CPU_IDLE,
    CPU_WAIT_VRAM,
    CPU_ACK
  } cpu_state_t;

  typedef enum logic [1:0] {
    VRAM_IDLE,
    VRAM_WRITE,
    VRAM_READ
  } vram_op_t;

  typedef enum logic [1:0] {
    PORT_DATA     = 2'd0,
    PORT_CTRL     = 2'd1,
    PORT_PALETTE  = 2'd2,
    PORT_INDIRECT = 2'd3
  } port_t;

endpackage

`default_nettype wire

// ==== verilog/vdp_timing.sv ====
// Fixed NTSC raster of 262 lines by 1368 clocks; no PAL, interlace or adjust support
`default_nettype none
`timescale 1ns/100ps

module vdp_timing
  import vdp_pkg::*;
(
  input  wire logic          reset,
  input  wire logic          clk21m,
  output dot_phase_t         phase,
  output logic [LINE_W-1:0]  line,
  output logic               line_start,
  output logic               vblank_start
);

  logic [H_CNT_W-1:0] hcnt;
  logic               last_clock;
  logic               last_line;

  assign last_clock = (hcnt == H_CNT_W'(CLOCKS_PER_LINE - 1));
  assign last_line  = (line == LINE_W'(LINES_PER_FRAME - 1));

  // ----------------------------------------
  // Clock and line counters
  // ----------------------------------------
  always_ff @(posedge reset or posedge clk21m) begin
    if (clk21m) begin
      hcnt <= '0;
      line <= '0;
    end else if (last_clock) begin
      hcnt <= '0;
      if (last_line) begin
        line <= '0;
      end else begin
        line <= line + 1'b1;
      end
    end else begin
      hcnt <= hcnt + 1'b1;
    end
  end

  // Line length is a multiple of four, so the phase never slips
  assign phase = dot_phase_t'(hcnt[1:0]);

  // First clock of every line
  assign line_start = (hcnt == '0);

  // First clock of the first blanking line
  assign vblank_start = line_start && (line == LINE_W'(ACTIVE_LINES));

endmodule

`default_nettype wire

// ==== verilog/vdp_cpu_port.sv ====
// One access at a time; req must not repeat before ack, modes 2 and 3 are acked and read as zero
`default_nettype none
`timescale 1ns/100ps

module vdp_cpu_port
  import vdp_pkg::*;
(
  input  wire logic                 reset,
  input  wire logic                 clk21m,
  input  wire logic                 req,
  input  wire logic                 wrt,
  input  wire logic [1:0]           mode,
  input  wire logic [7:0]           dbo,
  output logic                      ack,
  output logic [7:0]                dbi,
  output logic                      reg_wr,
  output logic [REG_NUM_W-1:0]      reg_num,
  output logic [7:0]                reg_data,
  output logic                      addr_set,
  output logic [7:0]                addr_lo,
  output logic [5:0]                addr_hi,
  output logic                      addr_rd,
  output logic                      data_wr,
  output logic [7:0]                wr_data,
  output logic                      data_rd,
  input  wire logic                 busy,
  input  wire logic [7:0]           rd_buf,
  input  wire logic [7:0]           status,
  output logic                      clr_vblank,
  output logic                      clr_line,
  input  wire logic [3:0]           status_ptr
);

  cpu_state_t state;
  port_t      port;
  logic       req_idle;
  logic       ctrl_wr2;
  logic       ctrl_rd;
  logic       ctrl_full;
  logic [7:0] ctrl_byte;
  logic       hold_wrt;
  logic [7:0] data_hold;

  assign port     = port_t'(mode);
  assign req_idle = req && (state == CPU_IDLE);
  assign ctrl_wr2 = req_idle && wrt && (port == PORT_CTRL) && ctrl_full;
  assign ctrl_rd  = req_idle && !wrt && (port == PORT_CTRL);

  // ----------------------------------------
  // Strobes to the other blocks
  // ----------------------------------------
  // Second control byte, bit 7 selects register write or address setup
  assign reg_wr   = ctrl_wr2 && dbo[7];
  assign reg_num  = dbo[REG_NUM_W-1:0];
  assign reg_data = ctrl_byte;
  assign addr_set = ctrl_wr2 && !dbo[7];
  assign addr_lo  = ctrl_byte;
  assign addr_hi  = dbo[5:0];
  assign addr_rd  = !dbo[6];

  assign clr_vblank = ctrl_rd && (status_ptr == 4'd0);
  assign clr_line   = ctrl_rd && (status_ptr == 4'd1);

  // Data port goes straight out when idle, else from the held request
  assign data_wr = !busy && ((req_idle && wrt && (port == PORT_DATA)) ||
                             ((state == CPU_WAIT_VRAM) && hold_wrt));
  assign data_rd = !busy && ((req_idle && !wrt && (port == PORT_DATA)) ||
                             ((state == CPU_WAIT_VRAM) && !hold_wrt));
  assign wr_data = (state == CPU_IDLE) ? dbo : data_hold;

  // ----------------------------------------
  // Access state machine
  // ----------------------------------------
  always_ff @(posedge reset or posedge clk21m) begin
    if (clk21m) begin
      state     <= CPU_IDLE;
      ack       <= 1'b0;
      dbi       <= '0;
      ctrl_full <= 1'b0;
      hold_wrt  <= 1'b0;
    end else begin
      ack <= 1'b0;
      case (state)
        CPU_IDLE: begin
          if (req) begin
            hold_wrt <= wrt;
            case (port)
              PORT_DATA: begin
                if (busy) begin
                  state <= CPU_WAIT_VRAM;
                end else if (wrt) begin
                  state <= CPU_ACK;
                end else begin
                  ack <= 1'b1;
                  dbi <= rd_buf;
                end
              end
              PORT_CTRL: begin
                ack <= 1'b1;
                if (wrt) begin
                  ctrl_full <= !ctrl_full;
                end else begin
                  ctrl_full <= 1'b0;
                  dbi       <= status;
                end
              end
              PORT_PALETTE, PORT_INDIRECT: begin
                ack <= 1'b1;
                dbi <= '0;
              end
              default: begin
                ack <= 1'b1;
              end
            endcase
          end
        end
        CPU_WAIT_VRAM: begin
          if (!busy) begin
            if (hold_wrt) begin
              state <= CPU_ACK;
            end else begin
              ack   <= 1'b1;
              dbi   <= rd_buf;
              state <= CPU_IDLE;
            end
          end
        end
        CPU_ACK: begin
          // Write has left the slot once busy drops
          if (!busy) begin
            ack   <= 1'b1;
            state <= CPU_IDLE;
          end
        end
        default: begin
          state <= CPU_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge reset) begin
    if (req_idle && wrt && (port == PORT_CTRL) && !ctrl_full) begin
      ctrl_byte <= dbo;
    end
    if (req_idle) begin
      data_hold <= dbo;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/vdp_registers.sv ====
// Only R0, R1, R14, R15 and R19 are kept; writes to any other register number are dropped
`default_nettype none
`timescale 1ns/100ps

module vdp_registers
  import vdp_pkg::*;
(
  input  wire logic                 reset,
  input  wire logic                 clk21m,
  input  wire logic                 reg_wr,
  input  wire logic [REG_NUM_W-1:0] reg_num,
  input  wire logic [7:0]           reg_data,
  output logic                      ie0,
  output logic                      ie1,
  output logic [2:0]                vram_hi,
  output logic [3:0]                status_ptr,
  output logic [7:0]                int_line,
  input  wire logic                 vblank_flag,
  input  wire logic                 line_flag,
  output logic [7:0]                status
);

  // ----------------------------------------
  // Register writes
  // ----------------------------------------
  // R0 and R1 only hold their interrupt enables here
  always_ff @(posedge reset or posedge clk21m) begin
    if (clk21m) begin
      ie1        <= 1'b0;
      ie0        <= 1'b0;
      vram_hi    <= '0;
      status_ptr <= '0;
      int_line   <= '0;
    end else if (reg_wr) begin
      case (reg_num)
        R_MODE0:      ie1        <= reg_data[IE1_BIT];
        R_MODE1:      ie0        <= reg_data[IE0_BIT];
        R_VRAM_HI:    vram_hi    <= reg_data[2:0];
        R_STATUS_PTR: status_ptr <= reg_data[3:0];
        R_INT_LINE:   int_line   <= reg_data;
        default: begin
        end
      endcase
    end
  end

  // ----------------------------------------
  // Status readback
  // ----------------------------------------
  always_comb begin
    case (status_ptr)
      4'd0:    status = {vblank_flag, 7'b0};
      4'd1:    status = {7'b0, line_flag};
      default: status = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== verilog/vdp_interrupt.sv ====
// Level interrupt; int_n stays low until the CPU reads the matching status register
`default_nettype none
`timescale 1ns/100ps

module vdp_interrupt
  import vdp_pkg::*;
(
  input  wire logic              reset,
  input  wire logic              clk21m,
  input  wire logic              vblank_start,
  input  wire logic              line_start,
  input  wire logic [LINE_W-1:0] line,
  input  wire logic [7:0]        int_line,
  input  wire logic              ie0,
  input  wire logic              ie1,
  input  wire logic              clr_vblank,
  input  wire logic              clr_line,
  output logic                   vblank_flag,
  output logic                   line_flag,
  output logic                   int_n
);

  logic line_match;

  assign line_match = line_start && (line == {1'b0, int_line});

  // Status read clear has priority over a new event
  always_ff @(posedge reset or posedge clk21m) begin
    if (clk21m) begin
      vblank_flag <= 1'b0;
      line_flag   <= 1'b0;
    end else begin
      if (clr_vblank) begin
        vblank_flag <= 1'b0;
      end else if (vblank_start) begin
        vblank_flag <= 1'b1;
      end
      if (clr_line) begin
        line_flag <= 1'b0;
      end else if (line_match) begin
        line_flag <= 1'b1;
      end
    end
  end

  assign int_n = !((vblank_flag && ie0) || (line_flag && ie1));

endmodule

`default_nettype wire

// ==== verilog/vdp_vram_access.sv ====
// One CPU operation pending at a time; the VRAM must answer the registered address in one clock
`default_nettype none
`timescale 1ns/100ps

module vdp_vram_access
  import vdp_pkg::*;
(
  input  wire logic                   reset,
  input  wire logic                   clk21m,
  input  wire dot_phase_t             phase,
  input  wire logic                   addr_set,
  input  wire logic [7:0]             addr_lo,
  input  wire logic [5:0]             addr_hi,
  input  wire logic                   addr_rd,
  input  wire logic [2:0]             vram_hi,
  input  wire logic                   data_wr,
  input  wire logic [7:0]             wr_data,
  input  wire logic                   data_rd,
  output logic                        busy,
  output logic [7:0]                  rd_buf,
  output logic [VRAM_ADDR_W-1:0]      pramadr,
  output logic [7:0]                  pramdbo_8,
  output logic                        pramwe_n,
  input  wire logic [15:0]            pramdbi_16
);

  vram_op_t               pend_op;
  logic [VRAM_ADDR_W-1:0] addr;
  logic [7:0]             wr_latch;
  logic                   rd_inflight;
  logic                   launch;

  // Issued at the end of PH_0 so the bus cycle sits in PH_1
  assign launch = (phase == PH_0) && (pend_op != VRAM_IDLE);
  assign busy   = (pend_op != VRAM_IDLE) || rd_inflight;

  // ----------------------------------------
  // Address counter and pending operation
  // ----------------------------------------
  always_ff @(posedge reset or posedge clk21m) begin
    if (clk21m) begin
      pend_op     <= VRAM_IDLE;
      addr        <= '0;
      rd_inflight <= 1'b0;
      pramwe_n    <= 1'b1;
    end else begin
      rd_inflight <= launch && (pend_op == VRAM_READ);
      pramwe_n    <= !(launch && (pend_op == VRAM_WRITE));
      if (launch) begin
        pend_op <= VRAM_IDLE;
        addr    <= addr + 1'b1;
      end
      // A new address overrides any prefetch in progress
      if (addr_set) begin
        addr <= {vram_hi, addr_hi, addr_lo};
        if (addr_rd) begin
          pend_op <= VRAM_READ;
        end else begin
          pend_op <= VRAM_IDLE;
        end
      end else if (data_wr) begin
        pend_op <= VRAM_WRITE;
      end else if (data_rd) begin
        pend_op <= VRAM_READ;
      end
    end
  end

  // ----------------------------------------
  // VRAM bus and read-ahead buffer
  // ----------------------------------------
  always_ff @(posedge reset) begin
    if (data_wr) begin
      wr_latch <= wr_data;
    end
    if (launch) begin
      pramadr   <= addr;
      pramdbo_8 <= wr_latch;
    end
    // Address bit 0 picks the byte lane of the 16-bit word
    if (rd_inflight) begin
      rd_buf <= pramadr[0] ? pramdbi_16[15:8] : pramdbi_16[7:0];
    end
  end

endmodule

`default_nettype wire

// ==== verilog/vdp_top.sv ====
// CPU-facing VDP core only; no video output, the clock port is reset and the async reset clk21m
`default_nettype none
`timescale 1ns/100ps

module vdp_top
  import vdp_pkg::*;
(
  input  wire logic                   reset,
  input  wire logic                   clk21m,
  input  wire logic                   req,
  input  wire logic                   wrt,
  input  wire logic [1:0]             mode,
  input  wire logic [7:0]             dbo,
  output logic                        ack,
  output logic [7:0]                  dbi,
  output logic                        int_n,
  output logic [VRAM_ADDR_W-1:0]      pramadr,
  output logic [7:0]                  pramdbo_8,
  output logic                        pramwe_n,
  input  wire logic [15:0]            pramdbi_16
);

  // ----------------------------------------
  // Internal nets
  // ----------------------------------------
  dot_phase_t             phase;
  logic [LINE_W-1:0]      line;
  logic                   line_start;
  logic                   vblank_start;
  logic                   reg_wr;
  logic [REG_NUM_W-1:0]   reg_num;
  logic [7:0]             reg_data;
  logic                   addr_set;
  logic [7:0]             addr_lo;
  logic [5:0]             addr_hi;
  logic                   addr_rd;
  logic                   data_wr;
  logic [7:0]             wr_data;
  logic                   data_rd;
  logic                   busy;
  logic [7:0]             rd_buf;
  logic [7:0]             status;
  logic                   clr_vblank;
  logic                   clr_line;
  logic [3:0]             status_ptr;
  logic                   ie0;
  logic                   ie1;
  logic [2:0]             vram_hi;
  logic [7:0]             int_line;
  logic                   vblank_flag;
  logic                   line_flag;

  vdp_timing u_timing (
    .reset        (reset),
    .clk21m       (clk21m),
    .phase        (phase),
    .line         (line),
    .line_start   (line_start),
    .vblank_start (vblank_start)
  );

  vdp_cpu_port u_cpu_port (
    .reset      (reset),
    .clk21m     (clk21m),
    .req        (req),
    .wrt        (wrt),
    .mode       (mode),
    .dbo        (dbo),
    .ack        (ack),
    .dbi        (dbi),
    .reg_wr     (reg_wr),
    .reg_num    (reg_num),
    .reg_data   (reg_data),
    .addr_set   (addr_set),
    .addr_lo    (addr_lo),
    .addr_hi    (addr_hi),
    .addr_rd    (addr_rd),
    .data_wr    (data_wr),
    .wr_data    (wr_data),
    .data_rd    (data_rd),
    .busy       (busy),
    .rd_buf     (rd_buf),
    .status     (status),
    .clr_vblank (clr_vblank),
    .clr_line   (clr_line),
    .status_ptr (status_ptr)
  );

  vdp_registers u_registers (
    .reset       (reset),
    .clk21m      (clk21m),
    .reg_wr      (reg_wr),
    .reg_num     (reg_num),
    .reg_data    (reg_data),
    .ie0         (ie0),
    .ie1         (ie1),
    .vram_hi     (vram_hi),
    .status_ptr  (status_ptr),
    .int_line    (int_line),
    .vblank_flag (vblank_flag),
    .line_flag   (line_flag),
    .status      (status)
  );

  vdp_interrupt u_interrupt (
    .reset        (reset),
    .clk21m       (clk21m),
    .vblank_start (vblank_start),
    .line_start   (line_start),
    .line         (line),
    .int_line     (int_line),
    .ie0          (ie0),
    .ie1          (ie1),
    .clr_vblank   (clr_vblank),
    .clr_line     (clr_line),
    .vblank_flag  (vblank_flag),
    .line_flag    (line_flag),
    .int_n        (int_n)
  );

  vdp_vram_access u_vram_access (
    .reset      (reset),
    .clk21m     (clk21m),
    .phase      (phase),
    .addr_set   (addr_set),
    .addr_lo    (addr_lo),
    .addr_hi    (addr_hi),
    .addr_rd    (addr_rd),
    .vram_hi    (vram_hi),
    .data_wr    (data_wr),
    .wr_data    (wr_data),
    .data_rd    (data_rd),
    .busy       (busy),
    .rd_buf     (rd_buf),
    .pramadr    (pramadr),
    .pramdbo_8  (pramdbo_8),
    .pramwe_n   (pramwe_n),
    .pramdbi_16 (pramdbi_16)
  );

endmodule

`default_nettype wire

// ==== dv/tb_vdp.sv ====
// Needs a simulator with timing support; runs about three NTSC frames and stops at the first error
`default_nettype none
`timescale 1ns/100ps

module tb_vdp
  import vdp_pkg::*;
();

  localparam int FRAME_CLOCKS = CLOCKS_PER_LINE * LINES_PER_FRAME;
  localparam int ACK_TIMEOUT  = 64;

  // Port reset is the clock, port clk21m the active-high reset
  logic                   reset;
  logic                   clk21m;
  logic                   req;
  logic                   wrt;
  logic [1:0]             mode;
  logic [7:0]             dbo;
  logic                   ack;
  logic [7:0]             dbi;
  logic                   int_n;
  logic [VRAM_ADDR_W-1:0] pramadr;
  logic [7:0]             pramdbo_8;
  logic                   pramwe_n;
  logic [15:0]            pramdbi_16;

  logic [15:0]            vram [0:65535];
  logic [7:0]             model_mem [0:131071];
  logic [VRAM_ADDR_W-1:0] seen_addr [$];
  logic [7:0]             seen_data [$];

  vdp_top dut_i (
    .reset      (reset),
    .clk21m     (clk21m),
    .req        (req),
    .wrt        (wrt),
    .mode       (mode),
    .dbo        (dbo),
    .ack        (ack),
    .dbi        (dbi),
    .int_n      (int_n),
    .pramadr    (pramadr),
    .pramdbo_8  (pramdbo_8),
    .pramwe_n   (pramwe_n),
    .pramdbi_16 (pramdbi_16)
  );

  // ----------------------------------------
  // Clock and VRAM
  // ----------------------------------------
  initial begin
    reset = 1'b0;
    forever #10 reset = ~reset;
  end

  function automatic logic [7:0] fill_byte(input logic [16:0] a);
    fill_byte = a[7:0] ^ a[15:8] ^ {7'b0, a[16]} ^ 8'h3c;
  endfunction

  // Asynchronous read of the registered address and a byte write mid-cycle
  assign pramdbi_16 = vram[pramadr[16:1]];

  initial begin
    for (int w = 0; w < 65536; w++) begin
      vram[w] = {fill_byte(17'(2 * w + 1)), fill_byte(17'(2 * w))};
    end
    forever begin
      @(negedge reset);
      if (!pramwe_n) begin
        if (pramadr[0]) begin
          vram[pramadr[16:1]][15:8] = pramdbo_8;
        end else begin
          vram[pramadr[16:1]][7:0] = pramdbo_8;
        end
      end
    end
  end

  // Every write strobe, taken at the clock edge that ends it
  always @(posedge reset) begin
    if (!pramwe_n) begin
      seen_addr.push_back(pramadr);
      seen_data.push_back(pramdbo_8);
    end
  end

  // ----------------------------------------
  // Failure reporting and checks
  // ----------------------------------------
  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("[FAIL] %0t ns: %s got 0x%0h, expected 0x%0h", $time, what, got, exp));
    end
  endtask

  // One CPU access that returns dbi once ack arrives
  task automatic bus_access(input logic wr_en, input logic [1:0] port, input logic [7:0] data,
                            output logic [7:0] rd_data);
    int cycles;
    @(negedge reset);
    req  = 1'b1;
    wrt  = wr_en;
    mode = port;
    dbo  = data;
    @(negedge reset);
    req    = 1'b0;
    cycles = 0;
    while (!ack && cycles < ACK_TIMEOUT) begin
      @(negedge reset);
      cycles++;
    end
    if (!ack) begin
      abort_run("Timeout: the CPU port never acknowledged an access");
    end
    rd_data = dbi;
  endtask

  task automatic write_ctrl(input logic [7:0] data);
    logic [7:0] unused_rd;
    bus_access(1'b1, PORT_CTRL, data, unused_rd);
  endtask

  task automatic write_reg(input logic [5:0] num, input logic [7:0] val);
    write_ctrl(val);
    write_ctrl({2'b10, num});
  endtask

  task automatic set_address(input logic [VRAM_ADDR_W-1:0] a, input logic write_mode);
    write_ctrl(a[7:0]);
    write_ctrl({1'b0, write_mode, a[13:8]});
  endtask

  task automatic check_vram_write(input logic [VRAM_ADDR_W-1:0] exp_addr,
                                  input logic [7:0] exp_data);
    logic [VRAM_ADDR_W-1:0] got_addr;
    logic [7:0]             got_data;
    check_value("write strobes per access", seen_addr.size(), 1);
    got_addr = seen_addr.pop_front();
    got_data = seen_data.pop_front();
    check_value("VRAM write address", 32'(got_addr), 32'(exp_addr));
    check_value("VRAM write data", 32'(got_data), 32'(exp_data));
  endtask

  task automatic wait_int_low(input int limit, input string what);
    int cycles;
    cycles = 0;
    while (int_n && cycles < limit) begin
      @(negedge reset);
      cycles++;
    end
    if (int_n) begin
      abort_run($sformatf("Timeout: int_n never fell for the %s", what));
    end
  endtask

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------
  initial begin
    logic [31:0]            rnd;
    logic [7:0]             rd;
    logic [7:0]             r14_val;
    logic [7:0]             wdata;
    logic [7:0]             line_sel;
    logic [15:0]            word;
    logic [VRAM_ADDR_W-1:0] base;
    logic [VRAM_ADDR_W-1:0] model_addr;
    logic [VRAM_ADDR_W-1:0] a;
    req    = 1'b0;
    wrt    = 1'b0;
    mode   = 2'd0;
    dbo    = 8'h00;
    clk21m = 1'b1;
    rnd    = $urandom(32'h1023);
    for (int b = 0; b < 131072; b++) begin
      model_mem[b] = fill_byte(17'(b));
    end
    repeat (5) @(negedge reset);
    clk21m = 1'b0;

    check_value("int_n after reset", 32'(int_n), 32'd1);
    check_value("pramwe_n after reset", 32'(pramwe_n), 32'd1);
    check_value("ack after reset", 32'(ack), 32'd0);

    // Random writes through the data port
    rnd     = $urandom;
    r14_val = rnd[7:0];
    write_reg(R_VRAM_HI, r14_val);
    rnd  = $urandom;
    base = {r14_val[2:0], rnd[13:0]};
    set_address(base, 1'b1);
    model_addr = base;
    for (int i = 0; i < 16; i++) begin
      rnd   = $urandom;
      wdata = rnd[7:0];
      bus_access(1'b1, PORT_DATA, wdata, rd);
      check_vram_write(model_addr, wdata);
      model_mem[model_addr] = wdata;
      model_addr = model_addr + 17'd1;
    end

    // Read-back through the read-ahead buffer
    set_address(base, 1'b0);
    model_addr = base;
    for (int i = 0; i < 16; i++) begin
      bus_access(1'b0, PORT_DATA, 8'h00, rd);
      check_value("data port read", 32'(rd), 32'(model_mem[model_addr]));
      model_addr = model_addr + 17'd1;
    end
    check_value("writes during read-back", seen_addr.size(), 0);

    // Vertical blank with IE0 on, then off
    bus_access(1'b0, PORT_CTRL, 8'h00, rd);
    write_reg(R_MODE1, 8'h20);
    wait_int_low(2 * FRAME_CLOCKS, "vertical blank");
    bus_access(1'b0, PORT_CTRL, 8'h00, rd);
    check_value("S0 vblank bit", 32'(rd[7]), 32'd1);
    check_value("int_n after S0 read", 32'(int_n), 32'd1);
    bus_access(1'b0, PORT_CTRL, 8'h00, rd);
    check_value("S0 after clear", 32'(rd), 32'd0);
    write_reg(R_MODE1, 8'h00);
    repeat (FRAME_CLOCKS + CLOCKS_PER_LINE) begin
      @(negedge reset);
      check_value("int_n with IE0 off", 32'(int_n), 32'd1);
    end
    bus_access(1'b0, PORT_CTRL, 8'h00, rd);
    check_value("S0 vblank bit with IE0 off", 32'(rd[7]), 32'd1);

    // Line interrupt at a random active line
    rnd      = $urandom % 32'd192;
    line_sel = rnd[7:0];
    write_reg(R_INT_LINE, line_sel);
    write_reg(R_STATUS_PTR, 8'h01);
    bus_access(1'b0, PORT_CTRL, 8'h00, rd);
    write_reg(R_MODE0, 8'h10);
    wait_int_low(FRAME_CLOCKS + CLOCKS_PER_LINE, "line match");
    bus_access(1'b0, PORT_CTRL, 8'h00, rd);
    check_value("S1 line bit", 32'(rd[0]), 32'd1);
    check_value("int_n after S1 read", 32'(int_n), 32'd1);
    write_reg(R_MODE0, 8'h00);
    write_reg(R_STATUS_PTR, 8'h00);
    check_value("writes during interrupt tests", seen_addr.size(), 0);

    // Palette and indirect ports are acked and read zero
    for (int p = 2; p < 4; p++) begin
      rnd = $urandom;
      bus_access(1'b1, 2'(p), rnd[7:0], rd);
      bus_access(1'b0, 2'(p), 8'h00, rd);
      check_value("palette or indirect port read", 32'(rd), 32'd0);
    end
    check_value("writes from palette or indirect ports", seen_addr.size(), 0);
    for (int i = 0; i < 16; i++) begin
      a    = base + 17'(i);
      word = vram[a[16:1]];
      check_value("VRAM content", 32'(a[0] ? word[15:8] : word[7:0]), 32'(model_mem[a]));
    end

    $display("RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== flist.f ====
verilog/vdp_pkg.sv
verilog/vdp_timing.sv
verilog/vdp_cpu_port.sv
verilog/vdp_registers.sv
verilog/vdp_interrupt.sv
verilog/vdp_vram_access.sv
verilog/vdp_top.sv
dv/tb_vdp.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile the VDP core and testbench with Verilator, then run it.
# The exit status of the simulation is the result of the run.
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 --timescale 1ns/100ps \
  --top-module tb_vdp -f flist.f --Mdir obj_dir -o Vtb_vdp

./obj_dir/Vtb_vdp
